//--- dv/apu_pulse_chk.sv
`timescale 1ns/1ps
`default_nettype none

module apu_pulse_chk #(
	parameter int MAX_CREDITS = 4
) (
	input wire              clk,
	input wire              rst_n,
	input apu_pkg::credit_t credits,
	input wire              sample_valid
);

	credit_over: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= apu_pkg::credit_t'(MAX_CREDITS))
	else $error("credit count above the sink depth");

	// A send in the previous cycle needed a credit
	send_no_credit: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(sample_valid) |-> $past(credits) != '0)
	else $error("sample sent without credit");

	valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		sample_valid |=> !sample_valid)
	else $error("sample_valid high on two cycles in a row");

endmodule

`default_nettype wire

//--- dv/apu_pulse_tb.sv
`timescale 1ns/1ps
`default_nettype none

module apu_pulse_tb;

	localparam int APU_DIV = 2;
	localparam int FRAME_DIV = 64;
	localparam int SAMPLE_DIV = 16;
	localparam int MAX_CREDITS = 4;
	localparam int QF = APU_DIV * FRAME_DIV;
	localparam int HF = 2 * QF;
	localparam int DUTY_WIN = 33000;
	localparam int ENV_WAIT = 7200;
	// Two duty runs, three mutes, length, envelope, credits and resets
	localparam int LIMIT = 2 * (2 * DUTY_WIN + 3 * 2000 + 3200 + ENV_WAIT + 500 + 200);

	logic clk;
	logic rst_n;
	logic bus_we;
	apu_pkg::bus_addr_t bus_addr;
	apu_pkg::bus_data_t bus_data;
	logic sample_credit;
	logic sink_credit;
	logic manual_credit;
	logic sample_valid;
	apu_pkg::level_t sample;
	apu_pkg::ovr_cnt_t overruns;

	logic withhold;
	int cycle;
	int t_wr;
	apu_pkg::level_t samples[$];
	int stamps[$];
	int delays[$];

	assign sample_credit = sink_credit | manual_credit;

	apu_pulse_top #(
		.APU_DIV     (APU_DIV),
		.FRAME_DIV   (FRAME_DIV),
		.SAMPLE_DIV  (SAMPLE_DIV),
		.MAX_CREDITS (MAX_CREDITS),
		.SWEEP_ONES  (1'b1)
	) u_apu_pulse_top (
		.clk           (clk),
		.rst_n         (rst_n),
		.bus_we        (bus_we),
		.bus_addr      (bus_addr),
		.bus_data      (bus_data),
		.sample_credit (sample_credit),
		.sample_valid  (sample_valid),
		.sample        (sample),
		.overruns      (overruns)
	);

	bind apu_sample_out apu_pulse_chk #(.MAX_CREDITS(MAX_CREDITS)) u_chk (
		.clk          (clk),
		.rst_n        (rst_n),
		.credits      (credits),
		.sample_valid (sample_valid)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= LIMIT) begin
			$display("Run exceeded its cycle limit of %0d", LIMIT);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	end

	// Collector samples away from the rising edge
	always @(negedge clk) begin
		if (rst_n && sample_valid) begin
			samples.push_back(sample);
			stamps.push_back(cycle);
			if (!withhold)
				delays.push_back(int'($urandom % 32'd4));
		end
	end

	// Sink returns one credit per sample after a short delay
	always @(posedge clk) begin
		#1;
		sink_credit = 1'b0;
		if (delays.size() > 0) begin
			if (delays[0] == 0) begin
				sink_credit = 1'b1;
				void'(delays.pop_front());
			end else begin
				delays[0] = delays[0] - 1;
			end
		end
	end

	function automatic int duty_ones(input int d);
		int n;
		n = 0;
		for (int i = 0; i < 8; i++)
			n += int'(apu_pkg::DUTY_PAT[d][i]);
		return n;
	endfunction

	// Sample phases quantize each step boundary by up to one phase
	function automatic real duty_tol(input int p);
		return 2.0 / real'(p + 1) + 0.01;
	endfunction

	function automatic int env_zero_cycles(input int e);
		return 16 * (e + 1) * QF;
	endfunction

	function automatic int expected_drops(input int edges);
		return edges / SAMPLE_DIV - MAX_CREDITS;
	endfunction

	task automatic fail_value(input string name, input int exp, input int act);
		$display("[ERROR] %s expected %0d actual %0d", name, exp, act);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_level(input string name, input apu_pkg::level_t exp,
		input apu_pkg::level_t act);
		if (exp !== act)
			fail_value(name, int'(exp), int'(act));
	endtask

	task automatic check_count(input string name, input apu_pkg::ovr_cnt_t exp,
		input apu_pkg::ovr_cnt_t act);
		if (exp !== act)
			fail_value(name, int'(exp), int'(act));
	endtask

	task automatic check_bool(input string name, input bit exp, input bit act);
		if (exp !== act)
			fail_value(name, int'(exp), int'(act));
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic apply_reset(input logic hold_credits);
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		bus_we = 1'b0;
		manual_credit = 1'b0;
		withhold = hold_credits;
		repeat (8) @(posedge clk);
		delays.delete();
		samples.delete();
		stamps.delete();
		#1;
		rst_n = 1'b1;
	endtask

	task automatic bus_write(input apu_pkg::bus_addr_t a, input apu_pkg::bus_data_t d);
		@(posedge clk);
		#1;
		bus_we = 1'b1;
		bus_addr = a;
		bus_data = d;
		@(posedge clk);
		#1;
		bus_we = 1'b0;
		t_wr = cycle;
	endtask

	task automatic setup_voice(input int duty, input bit halt, input bit cv, input int vol,
		input int sweep, input int period, input int idx);
		bus_write(apu_pkg::ADDR_STATUS, 8'h01);
		bus_write(apu_pkg::ADDR_DUTY, 8'((duty << 6) | (halt << 5) | (cv << 4) | vol));
		bus_write(apu_pkg::ADDR_SWEEP, 8'(sweep));
		bus_write(apu_pkg::ADDR_TLO, 8'(period & 255));
		bus_write(apu_pkg::ADDR_THI, 8'((idx << 3) | (period >> 8)));
		samples.delete();
		stamps.delete();
	endtask

	task automatic run_duty(input int d, input int vol, input int p);
		int high;
		real share;
		apply_reset(1'b0);
		setup_voice(d, 1'b1, 1'b1, vol, 0, p, 0);
		wait_cycles(DUTY_WIN);
		high = 0;
		foreach (samples[i]) begin
			if (samples[i] != '0) begin
				check_level("duty level", apu_pkg::level_t'(vol), samples[i]);
				high++;
			end
		end
		share = real'(high) / real'(samples.size());
		check_bool("duty share", 1'b1,
			share - real'(duty_ones(d)) / 8.0 <= duty_tol(p) &&
			real'(duty_ones(d)) / 8.0 - share <= duty_tol(p));
	endtask

	task automatic check_silent(input string name);
		check_bool({name, " samples arrived"}, 1'b1, samples.size() > 10);
		foreach (samples[i])
			check_level(name, '0, samples[i]);
	endtask

	initial begin
		int cur_w;
		int cur_max;
		int prev_max;
		int w;
		int ref_t;
		bit seen;
		clk = 1'b0;
		rst_n = 1'b0;
		bus_we = 1'b0;
		bus_addr = '0;
		bus_data = '0;
		sink_credit = 1'b0;
		manual_credit = 1'b0;
		withhold = 1'b0;
		cycle = 0;
		t_wr = 0;
		void'($urandom(92));

		run_duty(1, 9, 100);
		run_duty(3, 15, 100);

		// Short period, disabled voice, sweep overflow
		apply_reset(1'b0);
		setup_voice(2, 1'b1, 1'b1, 12, 0, 5, 0);
		wait_cycles(2000);
		check_silent("short period");
		apply_reset(1'b0);
		setup_voice(2, 1'b1, 1'b1, 12, 0, 100, 0);
		bus_write(apu_pkg::ADDR_STATUS, 8'h00);
		samples.delete();
		wait_cycles(2000);
		check_silent("disabled");
		apply_reset(1'b0);
		setup_voice(3, 1'b1, 1'b1, 12, 8'h81, 11'h7ff, 0);
		wait_cycles(2000);
		check_silent("sweep overflow");

		// Length counter with index 0
		apply_reset(1'b0);
		setup_voice(3, 1'b0, 1'b1, 15, 0, 100, 0);
		wait_cycles(3200);
		ref_t = int'(apu_pkg::LEN_TABLE[0]) * HF;
		seen = 1'b0;
		foreach (samples[i]) begin
			if (stamps[i] - t_wr < ref_t - HF - 2 * SAMPLE_DIV && samples[i] != '0)
				seen = 1'b1;
			if (stamps[i] - t_wr > ref_t + HF + 2 * SAMPLE_DIV)
				check_level("length expired", '0, samples[i]);
		end
		check_bool("length active", 1'b1, seen);

		// Envelope decay with divider period 2
		apply_reset(1'b0);
		setup_voice(3, 1'b0, 1'b0, 2, 0, 8, 1);
		wait_cycles(ENV_WAIT);
		ref_t = env_zero_cycles(2) + HF;
		cur_w = 0;
		cur_max = 0;
		prev_max = 16;
		foreach (samples[i]) begin
			if (stamps[i] - t_wr >= HF && stamps[i] - t_wr < ref_t) begin
				w = (stamps[i] - t_wr - HF) / QF;
				if (w != cur_w) begin
					if (cur_max > prev_max)
						check_level("envelope max", apu_pkg::level_t'(prev_max),
							apu_pkg::level_t'(cur_max));
					if (prev_max == 16)
						check_bool("envelope start", 1'b1, cur_max > 0);
					prev_max = cur_max;
					cur_max = 0;
					cur_w = w;
				end
				if (int'(samples[i]) > cur_max)
					cur_max = int'(samples[i]);
			end
			if (stamps[i] - t_wr >= ref_t)
				check_level("envelope end", '0, samples[i]);
		end

		// Credits withheld, then returned past the sink depth
		apply_reset(1'b1);
		repeat (160) @(posedge clk);
		@(negedge clk);
		check_bool("credit samples", 1'b1, samples.size() == MAX_CREDITS);
		check_count("overruns", apu_pkg::ovr_cnt_t'(expected_drops(160)), overruns);
		@(posedge clk);
		#1;
		manual_credit = 1'b1;
		wait_cycles(2 * MAX_CREDITS);
		manual_credit = 1'b0;
		wait_cycles((MAX_CREDITS + 2) * SAMPLE_DIV);
		check_bool("delivery resumed", 1'b1, samples.size() == 2 * MAX_CREDITS);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
	-f sources.f --top-module apu_pulse_tb
./obj_dir/Vapu_pulse_tb 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
fi
exit 1

//--- sources.f
src/apu_pkg.sv
src/apu_frame_seq.sv
src/apu_length_counter.sv
src/apu_pulse.sv
src/apu_sample_out.sv
src/apu_pulse_top.sv
dv/apu_pulse_chk.sv
dv/apu_pulse_tb.sv

//--- src/apu_frame_seq.sv
`timescale 1ns/1ps
`default_nettype none

module apu_frame_seq #(
	parameter int APU_DIV   = 2,
	parameter int FRAME_DIV = 64
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic apu_tick,
	output logic qframe,
	output logic hframe
);

	localparam int DW = (APU_DIV > 1) ? $clog2(APU_DIV) : 1;
	localparam int FW = (FRAME_DIV > 1) ? $clog2(FRAME_DIV) : 1;

	logic [DW-1:0] div_cnt;
	logic [FW-1:0] frame_cnt;
	logic apu_wrap;
	logic frame_wrap;
	apu_pkg::frame_step_e step;

	assign apu_wrap = (div_cnt == DW'(APU_DIV - 1));
	assign frame_wrap = apu_wrap && (frame_cnt == FW'(FRAME_DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt   <= '0;
			frame_cnt <= '0;
			step      <= apu_pkg::STEP_0;
			apu_tick  <= 1'b0;
			qframe    <= 1'b0;
			hframe    <= 1'b0;
		end else begin
			div_cnt  <= apu_wrap ? '0 : div_cnt + 1'b1;
			apu_tick <= apu_wrap;
			qframe   <= frame_wrap;
			// Half frame closes steps 1 and 3
			hframe   <= frame_wrap &&
				(step == apu_pkg::STEP_1 || step == apu_pkg::STEP_3);
			if (apu_wrap)
				frame_cnt <= frame_wrap ? '0 : frame_cnt + 1'b1;
			if (frame_wrap)
				step <= apu_pkg::frame_step_e'(step + 2'd1);
		end
	end

endmodule

`default_nettype wire

//--- src/apu_length_counter.sv
`timescale 1ns/1ps
`default_nettype none

module apu_length_counter (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                hframe,
	input  wire                en,
	input  wire                halt,
	input  wire                load,
	input  apu_pkg::len_idx_t  idx,
	output logic               gate
);

	apu_pkg::len_cnt_t count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (!en) begin
			count <= '0;
		end else if (load) begin
			count <= apu_pkg::LEN_TABLE[idx];
		end else if (hframe && !halt && count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign gate = (count != '0);

endmodule

`default_nettype wire

//--- src/apu_pkg.sv
`default_nettype none

package apu_pkg;

	typedef logic [3:0]  level_t;
	typedef logic [10:0] period_t;
	typedef logic [4:0]  len_idx_t;
	typedef logic [7:0]  len_cnt_t;
	typedef logic [4:0]  bus_addr_t;
	typedef logic [7:0]  bus_data_t;
	typedef logic [3:0]  credit_t;
	typedef logic [7:0]  ovr_cnt_t;
	typedef logic [1:0]  duty_t;

	localparam bus_addr_t ADDR_DUTY   = 5'h00;
	localparam bus_addr_t ADDR_SWEEP  = 5'h01;
	localparam bus_addr_t ADDR_TLO    = 5'h02;
	localparam bus_addr_t ADDR_THI    = 5'h03;
	localparam bus_addr_t ADDR_STATUS = 5'h15;

	// Length counter load values indexed by the 5-bit field of THI
	localparam len_cnt_t LEN_TABLE [32] = '{
		8'd10,  8'd254, 8'd20,  8'd2,   8'd40,  8'd4,   8'd80,  8'd6,
		8'd160, 8'd8,   8'd60,  8'd10,  8'd14,  8'd12,  8'd26,  8'd14,
		8'd12,  8'd16,  8'd24,  8'd18,  8'd48,  8'd20,  8'd96,  8'd22,
		8'd192, 8'd24,  8'd72,  8'd26,  8'd16,  8'd28,  8'd32,  8'd30
	};

	// Bit n is the output at sequencer step n; steps count down from 0
	localparam logic [7:0] DUTY_PAT [4] = '{
		8'b1000_0000,
		8'b1100_0000,
		8'b1111_0000,
		8'b0011_1111
	};

	typedef enum logic [1:0] {
		STEP_0,
		STEP_1,
		STEP_2,
		STEP_3
	} frame_step_e;

endpackage

`default_nettype wire

//--- src/apu_pulse.sv
`timescale 1ns/1ps
`default_nettype none

module apu_pulse #(
	parameter bit SWEEP_ONES = 1'b1
) (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire                 apu_tick,
	input  wire                 qframe,
	input  wire                 hframe,
	input  wire                 bus_we,
	input  apu_pkg::bus_addr_t  bus_addr,
	input  apu_pkg::bus_data_t  bus_data,
	output apu_pkg::level_t     level
);

	logic duty_we;
	logic swp_we;
	logic tlo_we;
	logic thi_we;
	logic stat_we;

	assign duty_we = bus_we && bus_addr == apu_pkg::ADDR_DUTY;
	assign swp_we  = bus_we && bus_addr == apu_pkg::ADDR_SWEEP;
	assign tlo_we  = bus_we && bus_addr == apu_pkg::ADDR_TLO;
	assign thi_we  = bus_we && bus_addr == apu_pkg::ADDR_THI;
	assign stat_we = bus_we && bus_addr == apu_pkg::ADDR_STATUS;

	apu_pkg::duty_t   duty;
	apu_pkg::level_t  vol;
	apu_pkg::period_t period;
	logic halt;
	logic const_vol;
	logic swp_en;
	logic swp_neg;
	logic [2:0] swp_period;
	logic [2:0] swp_shift;
	logic en;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			duty       <= '0;
			halt       <= 1'b0;
			const_vol  <= 1'b0;
			vol        <= '0;
			swp_en     <= 1'b0;
			swp_period <= '0;
			swp_neg    <= 1'b0;
			swp_shift  <= '0;
			en         <= 1'b0;
		end else begin
			if (duty_we)
				{duty, halt, const_vol, vol} <= bus_data;
			if (swp_we)
				{swp_en, swp_period, swp_neg, swp_shift} <= bus_data;
			if (stat_we)
				en <= bus_data[0];
		end
	end

	// Envelope restarts on the quarter frame after a THI write
	logic env_start;
	apu_pkg::level_t env_div;
	apu_pkg::level_t env_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			env_start <= 1'b0;
			env_div   <= '0;
			env_cnt   <= '0;
		end else begin
			if (thi_we)
				env_start <= 1'b1;
			else if (qframe)
				env_start <= 1'b0;
			if (qframe) begin
				if (env_start) begin
					env_div <= vol;
					env_cnt <= 4'hf;
				end else if (env_div == '0) begin
					env_div <= vol;
					if (env_cnt != '0)
						env_cnt <= env_cnt - 1'b1;
					else if (halt)
						env_cnt <= 4'hf;
				end else begin
					env_div <= env_div - 1'b1;
				end
			end
		end
	end

	// Sweep target; carry out of the add means overflow
	apu_pkg::period_t shifted;
	logic [11:0] swp_sum;
	logic swp_mute;
	logic swp_apply;
	logic swp_reload;
	logic [2:0] swp_div;

	assign shifted = period >> swp_shift;

	always_comb begin
		if (swp_neg)
			swp_sum = {1'b0, period} - {1'b0, shifted} - 12'(SWEEP_ONES);
		else
			swp_sum = {1'b0, period} + {1'b0, shifted};
	end

	assign swp_mute  = !swp_neg && swp_sum[11];
	assign swp_apply = hframe && swp_en && swp_div == '0 && swp_shift != '0 && !swp_sum[11];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			swp_reload <= 1'b0;
			swp_div    <= '0;
		end else begin
			if (swp_we)
				swp_reload <= 1'b1;
			else if (hframe)
				swp_reload <= 1'b0;
			if (hframe) begin
				if (swp_reload || swp_div == '0)
					swp_div <= swp_period;
				else
					swp_div <= swp_div - 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			period <= '0;
		else if (tlo_we)
			period[7:0] <= bus_data;
		else if (thi_we)
			period[10:8] <= bus_data[2:0];
		else if (swp_apply)
			period <= swp_sum[10:0];
	end

	// Timer and duty sequencer
	apu_pkg::period_t timer_cnt;
	logic [2:0] seq_step;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_cnt <= '0;
			seq_step  <= '0;
		end else if (thi_we) begin
			timer_cnt <= {bus_data[2:0], period[7:0]};
			seq_step  <= '0;
		end else if (apu_tick) begin
			if (timer_cnt == '0) begin
				timer_cnt <= period;
				seq_step  <= seq_step - 1'b1;
			end else begin
				timer_cnt <= timer_cnt - 1'b1;
			end
		end
	end

	logic len_gate;

	apu_length_counter u_length (
		.clk    (clk),
		.rst_n  (rst_n),
		.hframe (hframe),
		.en     (en),
		.halt   (halt),
		.load   (thi_we && en),
		.idx    (apu_pkg::len_idx_t'(bus_data[7:3])),
		.gate   (len_gate)
	);

	logic gate;

	assign gate = en && len_gate && !swp_mute && period[10:3] != '0 &&
		apu_pkg::DUTY_PAT[duty][seq_step];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			level <= '0;
		else
			level <= gate ? (const_vol ? vol : env_cnt) : '0;
	end

endmodule

`default_nettype wire

//--- src/apu_pulse_top.sv
`timescale 1ns/1ps
`default_nettype none

module apu_pulse_top #(
	parameter int APU_DIV     = 2,
	parameter int FRAME_DIV   = 64,
	parameter int SAMPLE_DIV  = 16,
	parameter int MAX_CREDITS = 4,
	parameter bit SWEEP_ONES  = 1'b1
) (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire                 bus_we,
	input  apu_pkg::bus_addr_t  bus_addr,
	input  apu_pkg::bus_data_t  bus_data,
	input  wire                 sample_credit,
	output logic                sample_valid,
	output apu_pkg::level_t     sample,
	output apu_pkg::ovr_cnt_t   overruns
);

	logic apu_tick;
	logic qframe;
	logic hframe;
	apu_pkg::level_t level;

	apu_frame_seq #(
		.APU_DIV   (APU_DIV),
		.FRAME_DIV (FRAME_DIV)
	) u_frame_seq (
		.clk      (clk),
		.rst_n    (rst_n),
		.apu_tick (apu_tick),
		.qframe   (qframe),
		.hframe   (hframe)
	);

	apu_pulse #(
		.SWEEP_ONES (SWEEP_ONES)
	) u_pulse (
		.clk      (clk),
		.rst_n    (rst_n),
		.apu_tick (apu_tick),
		.qframe   (qframe),
		.hframe   (hframe),
		.bus_we   (bus_we),
		.bus_addr (bus_addr),
		.bus_data (bus_data),
		.level    (level)
	);

	apu_sample_out #(
		.SAMPLE_DIV  (SAMPLE_DIV),
		.MAX_CREDITS (MAX_CREDITS)
	) u_sample_out (
		.clk           (clk),
		.rst_n         (rst_n),
		.level         (level),
		.sample_credit (sample_credit),
		.sample_valid  (sample_valid),
		.sample        (sample),
		.overruns      (overruns)
	);

endmodule

`default_nettype wire

//--- src/apu_sample_out.sv
`timescale 1ns/1ps
`default_nettype none

module apu_sample_out #(
	parameter int SAMPLE_DIV  = 16,
	parameter int MAX_CREDITS = 4
) (
	input  wire                clk,
	input  wire                rst_n,
	input  apu_pkg::level_t    level,
	input  wire                sample_credit,
	output logic               sample_valid,
	output apu_pkg::level_t    sample,
	output apu_pkg::ovr_cnt_t  overruns
);

	localparam int RW = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
	localparam apu_pkg::credit_t CREDIT_MAX = apu_pkg::credit_t'(MAX_CREDITS);

	logic [RW-1:0] rate_cnt;
	logic instant;
	logic send;
	logic take_credit;
	apu_pkg::credit_t credits;

	assign instant = (rate_cnt == RW'(SAMPLE_DIV - 1));
	assign send = instant && credits != '0;
	// A returned credit is kept unless the count is already full
	assign take_credit = sample_credit && (credits != CREDIT_MAX || send);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rate_cnt     <= '0;
			credits      <= CREDIT_MAX;
			sample_valid <= 1'b0;
			overruns     <= '0;
		end else begin
			rate_cnt     <= instant ? '0 : rate_cnt + 1'b1;
			sample_valid <= send;
			credits      <= credits + apu_pkg::credit_t'(take_credit) -
				apu_pkg::credit_t'(send);
			if (instant && !send && overruns != 8'hff)
				overruns <= overruns + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (instant)
			sample <= level;
	end

endmodule

`default_nettype wire
